/* logic/corePkg.sv */
package corePkg;

  ////////////////////////////////////////////////////////////
  // Widths

  // Host word is code + data
  localparam int codeWidth = 8;
  localparam int dataWidth = 24;
  localparam int pcWordWidth = codeWidth + dataWidth;

  // Chip side, downstream word is 21 data bits plus parity
  localparam int bdOutWidth = 22;
  localparam int bdDownWidth = bdOutWidth - 1;
  localparam int bdInWidth = 34;
  // Each upstream half fits in 17 bits
  localparam int serHalfWidth = bdInWidth / 2;

  // Time manager
  localparam int timeWidth = 48;
  localparam int unitWidth = 16;

  ////////////////////////////////////////////////////////////
  // Vector types

  typedef logic [codeWidth-1:0] codeT;
  typedef logic [dataWidth-1:0] dataT;
  typedef logic [pcWordWidth-1:0] pcWordT;
  typedef logic [bdDownWidth-1:0] bdDownT;
  typedef logic [bdOutWidth-1:0] bdOutT;
  typedef logic [bdInWidth-1:0] bdInT;
  typedef logic [timeWidth-1:0] timeT;
  typedef logic [unitWidth-1:0] unitT;

  ////////////////////////////////////////////////////////////
  // Host codes

  // Register writes occupy codeRegBase .. codeRegBase+regCount-1
  localparam codeT codeRegBase = 8'h00;
  localparam codeT codeBdWord = 8'h40;
  localparam codeT codeBdHigh = 8'h80;
  localparam codeT codeBdLow = 8'h81;
  localparam codeT codeHbHigh = 8'hC0;
  localparam codeT codeHbLow = 8'hC1;

  // Register indices
  localparam int regUnitLen = 0;
  localparam int regHbInterval = 1;
  localparam int regStall = 2;
  localparam int regCount = 4;

  // Configuration seen by the datapath
  typedef struct packed {
    unitT unitLen;
    unitT hbInterval;
    logic stall;
  } confT;

  localparam confT confReset = '{unitLen: 16'd3, hbInterval: 16'd4, stall: 1'b0};

endpackage

/* logic/pcParser.sv */
`timescale 1ns/1ps

module pcParser
  import corePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  pcWordT pcInData,
  input  logic   pcInValid,
  output logic   pcInReady,
  output bdDownT downData,
  output logic   downValid,
  input  logic   downReady,
  output confT   conf
);

  // Host word fields
  codeT code;
  dataT data;
  // Offset from the register code base
  codeT regIdx;
  logic isReg;
  logic isBd;
  logic regWrite;
  confT confQ;

  assign code = pcInData[pcWordWidth-1 -: codeWidth];
  assign data = pcInData[dataWidth-1:0];

  // Wraps for codes below the base, so one compare covers the range
  assign regIdx = code - codeRegBase;
  assign isReg = regIdx < codeT'(regCount);
  assign isBd = code == codeBdWord;

  ////////////////////////////////////////////////////////////
  // Handshake

  // Chip words wait on the encoder, everything else is eaten at once
  assign pcInReady = isBd ? downReady : 1'b1;
  assign downValid = pcInValid && isBd;
  // Only the low 21 bits go to the chip
  assign downData = data[bdDownWidth-1:0];

  assign regWrite = pcInValid && isReg;

  ////////////////////////////////////////////////////////////
  // Config registers

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      confQ <= confReset;
    end else if (regWrite) begin
      case (regIdx)
        codeT'(regUnitLen): confQ.unitLen <= data[unitWidth-1:0];
        codeT'(regHbInterval): confQ.hbInterval <= data[unitWidth-1:0];
        codeT'(regStall): confQ.stall <= data[0];
        // Spare register slot, write accepted and ignored
        default: confQ <= confQ;
      endcase
    end
  end

  assign conf = confQ;

endmodule

/* logic/timeMgr.sv */
`timescale 1ns/1ps

module timeMgr
  import corePkg::*;
(
  input  logic clk,
  input  logic arstN,
  input  confT conf,
  output logic unitPulse,
  output logic hbPulse,
  output timeT timeElapsed
);

  // Cycles within the current unit
  unitT cycleCount;
  // Units within the current heartbeat interval
  unitT hbCount;
  logic unitEnd;
  logic hbEnd;

  assign unitEnd = cycleCount >= conf.unitLen;
  // Zero interval never fires
  assign hbEnd = (conf.hbInterval != '0) && (hbCount >= conf.hbInterval - 16'd1);

  ////////////////////////////////////////////////////////////
  // Unit divider

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cycleCount <= '0;
      unitPulse <= 1'b0;
    end else begin
      unitPulse <= unitEnd;
      cycleCount <= unitEnd ? '0 : cycleCount + 16'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Elapsed time and heartbeat

  // hbPulse lines up with the new timeElapsed value
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      timeElapsed <= '0;
      hbCount <= '0;
      hbPulse <= 1'b0;
    end else begin
      hbPulse <= 1'b0;
      if (unitPulse) begin
        timeElapsed <= timeElapsed + 48'd1;
        if (hbEnd) begin
          hbCount <= '0;
          hbPulse <= 1'b1;
        end else if (conf.hbInterval != '0) begin
          hbCount <= hbCount + 16'd1;
        end
      end
    end
  end

endmodule

/* logic/bdEncoder.sv */
`timescale 1ns/1ps

module bdEncoder
  import corePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  bdDownT downData,
  input  logic   downValid,
  output logic   downReady,
  input  logic   stall,
  output bdOutT  bdOutData,
  output logic   bdOutValid,
  input  logic   bdOutReady
);

  // One-entry output stage
  logic full;
  bdOutT wordQ;
  logic leaving;
  logic accept;
  logic parity;

  // Odd parity, total ones including bit 21 is odd
  assign parity = ~^downData;

  // Stall only hides the word, it stays in the buffer
  assign bdOutValid = full && !stall;
  assign leaving = bdOutValid && bdOutReady;
  assign downReady = !full || leaving;
  assign accept = downValid && downReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (leaving) begin
      full <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (accept) begin
      wordQ <= {parity, downData};
    end
  end

  assign bdOutData = wordQ;

endmodule

/* logic/bdSerializer.sv */
`timescale 1ns/1ps

module bdSerializer
  import corePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  bdInT   bdInData,
  input  logic   bdInValid,
  output logic   bdInReady,
  output pcWordT serData,
  output logic   serValid,
  input  logic   serReady,
  output logic   serLast
);

  typedef enum logic {
    sendHigh,
    sendLow
  } serStateT;

  serStateT state;
  logic full;
  bdInT wordQ;
  logic accept;
  logic sent;

  // Zero pad each 17-bit half up to 24 data bits
  localparam int padWidth = dataWidth - serHalfWidth;

  assign serValid = full;
  assign serLast = state == sendLow;
  assign serData = (state == sendHigh)
    ? {codeBdHigh, {padWidth{1'b0}}, wordQ[bdInWidth-1:serHalfWidth]}
    : {codeBdLow, {padWidth{1'b0}}, wordQ[serHalfWidth-1:0]};

  assign sent = serValid && serReady;
  // Next word can land as the low half goes out
  assign bdInReady = !full || (serLast && serReady);
  assign accept = bdInValid && bdInReady;

  ////////////////////////////////////////////////////////////
  // Half sequencing

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= sendHigh;
      full <= 1'b0;
    end else if (accept) begin
      state <= sendHigh;
      full <= 1'b1;
    end else if (sent) begin
      if (state == sendHigh) begin
        state <= sendLow;
      end else begin
        state <= sendHigh;
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wordQ <= bdInData;
    end
  end

endmodule

/* logic/pcPacker.sv */
`timescale 1ns/1ps

module pcPacker
  import corePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  pcWordT serData,
  input  logic   serValid,
  output logic   serReady,
  input  logic   serLast,
  input  logic   hbPulse,
  input  timeT   timeElapsed,
  output pcWordT pcOutData,
  output logic   pcOutValid,
  input  logic   pcOutReady
);

  typedef enum logic [1:0] {
    idle,
    inPair,
    hbHigh,
    hbLow
  } packStateT;

  packStateT state;
  logic hbPending;
  timeT hbTime;
  // Low half kept apart so a fresh pulse cannot corrupt it
  dataT hbLowQ;
  pcWordT outQ;
  logic canLoad;
  logic takeSer;
  logic sendHbHigh;

  // Output register free now or draining this cycle
  assign canLoad = !pcOutValid || pcOutReady;

  // Chip words only between heartbeats, and low halves always
  assign serReady = canLoad && (((state == idle) && !hbPending) || (state == inPair));
  assign takeSer = serValid && serReady;
  assign sendHbHigh = canLoad && (state == hbHigh);

  ////////////////////////////////////////////////////////////
  // Heartbeat capture

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hbPending <= 1'b0;
    end else if (hbPulse) begin
      hbPending <= 1'b1;
    end else if (sendHbHigh) begin
      hbPending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hbPulse) begin
      hbTime <= timeElapsed;
    end
    if (sendHbHigh) begin
      hbLowQ <= hbTime[dataWidth-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Arbitration and output register

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
      pcOutValid <= 1'b0;
    end else begin
      if (canLoad) begin
        pcOutValid <= takeSer || (state == hbHigh) || (state == hbLow);
      end
      case (state)
        idle: begin
          if (hbPending) begin
            state <= hbHigh;
          end else if (takeSer && !serLast) begin
            state <= inPair;
          end
        end
        inPair: if (takeSer && serLast) state <= idle;
        hbHigh: if (canLoad) state <= hbLow;
        hbLow: if (canLoad) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Output payload
  always_ff @(posedge clk) begin
    if (takeSer) begin
      outQ <= serData;
    end else if (sendHbHigh) begin
      outQ <= {codeHbHigh, hbTime[timeWidth-1:dataWidth]};
    end else if (canLoad && (state == hbLow)) begin
      outQ <= {codeHbLow, hbLowQ};
    end
  end

  assign pcOutData = outQ;

endmodule

/* logic/bdCore.sv */
`timescale 1ns/1ps

module bdCore
  import corePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  // Host side
  input  pcWordT pcInData,
  input  logic   pcInValid,
  output logic   pcInReady,
  output pcWordT pcOutData,
  output logic   pcOutValid,
  input  logic   pcOutReady,
  // Chip side
  output bdOutT  bdOutData,
  output logic   bdOutValid,
  input  logic   bdOutReady,
  input  bdInT   bdInData,
  input  logic   bdInValid,
  output logic   bdInReady
);

  ////////////////////////////////////////////////////////////
  // Internal links

  // Parser to encoder
  bdDownT downData;
  logic downValid;
  logic downReady;
  confT conf;

  // Time base, unit pulse stays inside the time manager
  logic hbPulse;
  timeT timeElapsed;

  // Serializer to packer
  pcWordT serData;
  logic serValid;
  logic serReady;
  logic serLast;

  ////////////////////////////////////////////////////////////
  // Host to chip

  pcParser parser0 (
    .clk, .arstN,
    .pcInData, .pcInValid, .pcInReady,
    .downData, .downValid, .downReady,
    .conf
  );

  timeMgr timeMgr0 (
    .clk, .arstN,
    .conf,
    .unitPulse(), .hbPulse, .timeElapsed
  );

  bdEncoder encoder0 (
    .clk, .arstN,
    .downData, .downValid, .downReady,
    .stall(conf.stall),
    .bdOutData, .bdOutValid, .bdOutReady
  );

  // Chip to host
  bdSerializer serializer0 (
    .clk, .arstN,
    .bdInData, .bdInValid, .bdInReady,
    .serData, .serValid, .serReady, .serLast
  );

  pcPacker packer0 (
    .clk, .arstN,
    .serData, .serValid, .serReady, .serLast,
    .hbPulse, .timeElapsed,
    .pcOutData, .pcOutValid, .pcOutReady
  );

endmodule

/* sim/bdCoreTb.sv */
`timescale 1ns/1ps

module bdCoreTb
  import corePkg::*;
();

  // Stimulus lengths in cycles
  localparam int quietA = 400;
  localparam int quietB = 600;
  localparam int randCycles = 3000;
  localparam int stallCycles = 40;
  localparam int stimCycles = quietA + quietB + randCycles + stallCycles;
  localparam int cycleLimit = 4 * stimCycles + 2000;
  // Timing chosen for the second heartbeat test
  localparam unitT testUnitLen = 16'd2;
  localparam unitT testHbInterval = 16'd3;

  logic clk = 1'b0;
  logic arstN;
  pcWordT pcInData;
  logic pcInValid;
  logic pcInReady;
  pcWordT pcOutData;
  logic pcOutValid;
  logic pcOutReady;
  bdOutT bdOutData;
  logic bdOutValid;
  logic bdOutReady;
  bdInT bdInData;
  logic bdInValid;
  logic bdInReady;

  // Reference model state
  bdOutT bdQ[$];
  pcWordT upQ[$];
  confT confModel;
  codeT prevCode;
  dataT hbHighPart;
  timeT lastHbTime;
  int hbSeen = 0;
  logic stallWatch = 1'b0;

  // Bookkeeping
  integer seed;
  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int testCount = 0;
  int errAtStart = 0;
  int checksAtStart = 0;

  bdCore dut0 (
    .clk, .arstN,
    .pcInData, .pcInValid, .pcInReady,
    .pcOutData, .pcOutValid, .pcOutReady,
    .bdOutData, .bdOutValid, .bdOutReady,
    .bdInData, .bdInValid, .bdInReady
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycleLimit) begin
      $display("Timeout: run stopped after %0d cycles with %0d errors", cycle, errors);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare and report

  task flagError(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task checkBdOut(input string name, input bdOutT got, input bdOutT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task checkPcWord(input string name, input pcWordT got, input pcWordT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task checkTime(input string name, input timeT got, input timeT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task startTest;
    errAtStart = errors;
    checksAtStart = checks;
  endtask

  task finishTest(input string name);
    testCount++;
    $display("%s: %0d checks, %0d errors", name, checks - checksAtStart, errors - errAtStart);
  endtask

  ////////////////////////////////////////////////////////////
  // Model helpers

  // Bit 21 set when the data holds an even number of ones
  function automatic logic oddParityBit(input bdDownT d);
    int ones;
    ones = 0;
    for (int i = 0; i < bdDownWidth; i++) begin
      ones = ones + int'(d[i]);
    end
    return (ones % 2) == 0;
  endfunction

  // Host word leaving the core, pairs and heartbeat rules
  task followHostOutput(input pcWordT w);
    codeT code;
    timeT hbTime;
    code = w[31:24];
    if (prevCode == codeBdHigh && code != codeBdLow) begin
      flagError("chip word pair split on pcOut");
    end
    if (prevCode == codeHbHigh && code != codeHbLow) begin
      flagError("heartbeat pair split on pcOut");
    end
    if (code == codeHbLow && prevCode != codeHbHigh) begin
      flagError("heartbeat low word without its high word on pcOut");
    end
    if (code == codeBdHigh || code == codeBdLow) begin
      if (upQ.size() == 0) begin
        flagError("chip word on pcOut without a matching bdIn word");
      end else begin
        checkPcWord("pcOutData", w, upQ.pop_front());
      end
    end else if (code == codeHbHigh) begin
      hbHighPart = w[23:0];
    end else if (code == codeHbLow) begin
      hbTime = {hbHighPart, w[23:0]};
      hbSeen++;
      if (hbTime == '0) begin
        flagError("heartbeat time is zero");
      end
      checkTime("heartbeat time mod hbInterval", hbTime % timeT'(confModel.hbInterval), '0);
      if (hbTime <= lastHbTime) begin
        flagError($sformatf("heartbeat time %0d not above previous %0d", hbTime, lastHbTime));
      end
      lastHbTime = hbTime;
    end else begin
      flagError($sformatf("unknown code %h on pcOut", code));
    end
    prevCode = code;
  endtask

  // Fed from transfers at the DUT ports
  always @(posedge clk) begin : modelUpdate
    codeT inCode;
    bdDownT downWord;
    if (!arstN) begin
      bdQ.delete();
      upQ.delete();
      confModel = confReset;
      prevCode = 8'h00;
      hbHighPart = '0;
      lastHbTime = '0;
    end else begin
      if (pcInValid && pcInReady) begin
        inCode = pcInData[31:24];
        downWord = pcInData[bdDownWidth-1:0];
        case (inCode)
          codeBdWord: bdQ.push_back({oddParityBit(downWord), downWord});
          codeRegBase + codeT'(regUnitLen): confModel.unitLen = pcInData[unitWidth-1:0];
          codeRegBase + codeT'(regHbInterval): confModel.hbInterval = pcInData[unitWidth-1:0];
          codeRegBase + codeT'(regStall): confModel.stall = pcInData[0];
          default: confModel = confModel;
        endcase
      end
      if (stallWatch && bdOutValid) begin
        flagError("bdOutValid high while the chip output is stalled");
      end
      if (bdOutValid && bdOutReady) begin
        if (bdQ.size() == 0) begin
          flagError("chip word on bdOut without a matching host word");
        end else begin
          checkBdOut("bdOutData", bdOutData, bdQ.pop_front());
        end
      end
      // High half then low half, both zero extended
      if (bdInValid && bdInReady) begin
        upQ.push_back({codeBdHigh, dataT'(bdInData[33:17])});
        upQ.push_back({codeBdLow, dataT'(bdInData[16:0])});
      end
      if (pcOutValid && pcOutReady) begin
        followHostOutput(pcOutData);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus

  function automatic pcWordT randHostWord();
    logic [31:0] r;
    logic [31:0] d;
    codeT code;
    dataT data;
    r = $random(seed);
    d = $random(seed);
    data = d[dataWidth-1:0];
    case (r[2:0])
      3'd0, 3'd1: begin
        code = codeRegBase + codeT'(r[4:3]);
        // Timing registers rewritten with their own value, stall kept clear
        if (r[4:3] == 2'd0) begin
          data[unitWidth-1:0] = confModel.unitLen;
        end else if (r[4:3] == 2'd1) begin
          data[unitWidth-1:0] = confModel.hbInterval;
        end else if (r[4:3] == 2'd2) begin
          data[0] = 1'b0;
        end
      end
      3'd6, 3'd7: begin
        code = r[15:8];
        if (code <= 8'h03 || code == codeBdWord) begin
          code = 8'h3F;
        end
      end
      default: code = codeBdWord;
    endcase
    return {code, data};
  endfunction

  function automatic bdInT randChipWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[1:0], lo};
  endfunction

  function automatic pcWordT randDownWord();
    logic [31:0] d;
    d = $random(seed);
    return {codeBdWord, d[dataWidth-1:0]};
  endfunction

  task applyReset;
    arstN <= 1'b0;
    pcInData <= '0;
    pcInValid <= 1'b0;
    pcOutReady <= 1'b0;
    bdOutReady <= 1'b0;
    bdInData <= '0;
    bdInValid <= 1'b0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
  endtask

  task sendHost(input pcWordT w);
    pcInData <= w;
    pcInValid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!pcInReady);
    pcInValid <= 1'b0;
  endtask

  task runRandomTraffic(input int nCycles);
    logic [31:0] r;
    repeat (nCycles) begin
      @(posedge clk);
      r = $random(seed);
      // New word only once the previous one has moved
      if (!pcInValid || pcInReady) begin
        pcInValid <= r[0];
        pcInData <= randHostWord();
      end
      if (!bdInValid || bdInReady) begin
        bdInValid <= r[1];
        bdInData <= randChipWord();
      end
      bdOutReady <= r[2];
      pcOutReady <= r[3] | r[4];
    end
  endtask

  task releaseInputs;
    logic pcBusy;
    logic bdBusy;
    pcBusy = 1'b1;
    bdBusy = 1'b1;
    while (pcBusy || bdBusy) begin
      @(posedge clk);
      if (!pcInValid || pcInReady) begin
        pcInValid <= 1'b0;
        pcBusy = 1'b0;
      end
      if (!bdInValid || bdInReady) begin
        bdInValid <= 1'b0;
        bdBusy = 1'b0;
      end
    end
  endtask

  // One edge first so the last input transfer is already queued
  task drainOutputs;
    bdOutReady <= 1'b1;
    pcOutReady <= 1'b1;
    @(posedge clk);
    while (bdQ.size() != 0 || upQ.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Heartbeats over a quiet window against units per interval
  task checkHeartbeatRate(input int window);
    int startCount;
    int expected;
    int got;
    startCount = hbSeen;
    repeat (window) @(posedge clk);
    got = hbSeen - startCount;
    expected = (window / (int'(confModel.unitLen) + 1)) / int'(confModel.hbInterval);
    if (got < expected - 1 || got > expected + 1) begin
      flagError($sformatf("%0d heartbeats in %0d cycles, about %0d expected",
                          got, window, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed = 55902;

    // Reset state and default timing
    startTest();
    applyReset();
    @(posedge clk);
    if (pcOutValid !== 1'b0) begin
      flagError("pcOutValid not low directly after reset");
    end
    if (bdOutValid !== 1'b0) begin
      flagError("bdOutValid not low directly after reset");
    end
    pcOutReady <= 1'b1;
    bdOutReady <= 1'b1;
    checkHeartbeatRate(quietA);
    finishTest("reset and default heartbeat");

    // Timing written before the first unit ends keeps the count aligned
    startTest();
    applyReset();
    sendHost({codeRegBase + codeT'(regHbInterval), 8'h00, testHbInterval});
    sendHost({codeRegBase + codeT'(regUnitLen), 8'h00, testUnitLen});
    pcOutReady <= 1'b1;
    bdOutReady <= 1'b1;
    checkHeartbeatRate(quietB);
    finishTest("heartbeat with chosen timing");

    // Both directions at once under random backpressure
    startTest();
    runRandomTraffic(randCycles);
    releaseInputs();
    drainOutputs();
    finishTest("random traffic");

    // Held word in the encoder, next one blocked at the parser
    startTest();
    sendHost({codeRegBase + codeT'(regStall), 24'h000001});
    @(posedge clk);
    stallWatch <= 1'b1;
    sendHost(randDownWord());
    pcInData <= randDownWord();
    pcInValid <= 1'b1;
    repeat (stallCycles) begin
      @(posedge clk);
      if (pcInReady) begin
        flagError("chip word accepted while the full encoder was stalled");
      end
    end
    pcInValid <= 1'b0;
    stallWatch <= 1'b0;
    sendHost({codeRegBase + codeT'(regStall), 24'h000000});
    repeat (3) sendHost(randDownWord());
    drainOutputs();
    finishTest("stall");

    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* bdCore.f */
logic/corePkg.sv
logic/pcParser.sv
logic/timeMgr.sv
logic/bdEncoder.sv
logic/bdSerializer.sv
logic/pcPacker.sv
logic/bdCore.sv
sim/bdCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= bdCoreTb
FILELIST ?= bdCore.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
FAIL_MSG ?= Test failed

BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
